/* source/tetris_defines.svh */
// playfield size, spawn point and timing defaults, included by the RTL and the testbench
`ifndef TETRIS_DEFINES_SVH
`define TETRIS_DEFINES_SVH

// empty playfield, row 0 at the top
`define TETRIS_ROWS 20
`define TETRIS_COLS 10

// origin after reset
`define TETRIS_SPAWN_ROW 0
`define TETRIS_SPAWN_COL 4

// hold-off after an accepted press, 200 ms at 50 MHz
`define TETRIS_COOLDOWN_CYCLES 10000000

// 50 MHz board clock
`define TETRIS_TICKS_PER_MS 50000

`endif

/* source/tetris_pkg.sv */
// shared types for the piece tracker and the sprint timer, used by scoped name
package tetris_pkg;

    // playfield coordinates
    typedef logic [4:0] row_t;
    typedef logic [3:0] col_t;

    // clockwise order, so +1 is a clockwise turn
    typedef enum logic [1:0] {
        ORIENT_0 = 2'd0,
        ORIENT_R = 2'd1,
        ORIENT_2 = 2'd2,
        ORIENT_L = 2'd3
    } orientation_t;

    // timer fields
    typedef logic [3:0] decimal_digit_t;
    typedef logic [5:0] sexagesimal_t;
    typedef logic [4:0] hours_t;

endpackage

/* source/key_channel.sv */
// one push-button channel: synchronizer, rising-edge press strobe and cooldown hold-off
`timescale 1ns/10ps
`include "tetris_defines.svh"

module key_channel #(
    parameter int COOLDOWN_CYCLES = `TETRIS_COOLDOWN_CYCLES
) (
    input  logic clk,
    input  logic rst_l,
    input  logic key_n,
    output logic press
);
    localparam int CD_W = $clog2(COOLDOWN_CYCLES + 1);

    logic            key_meta;
    logic            key_seen;
    logic [CD_W-1:0] cooldown;
    logic            armed;

    // two flops, inverted so 1 means held down
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            key_meta <= 1'b0;
            key_seen <= 1'b0;
        end else begin
            key_meta <= !key_n;
            key_seen <= key_meta;
        end
    end

    assign armed = (cooldown == '0);

    // starts on a strobe, runs to the limit and drops back to idle
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            cooldown <= '0;
        end else if (cooldown == CD_W'(COOLDOWN_CYCLES)) begin
            cooldown <= '0;
        end else if (cooldown != '0 || press) begin
            cooldown <= cooldown + CD_W'(1);
        end
    end

    // single-cycle strobe, repeats while held once the cooldown expires
    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            press <= 1'b0;
        end else begin
            press <= key_seen && !press && armed;
        end
    end

endmodule

/* source/piece_origin_tracker.sv */
// origin and orientation of the falling piece, moved by key strobes inside the empty playfield
`timescale 1ns/10ps
`include "tetris_defines.svh"

module piece_origin_tracker (
    input  logic                     clk,
    input  logic                     rst_l,
    input  logic                     rotate_mode,
    input  logic                     left_press,
    input  logic                     right_press,
    input  logic                     soft_press,
    input  logic                     hard_press,
    output tetris_pkg::row_t         origin_row,
    output tetris_pkg::col_t         origin_col,
    output tetris_pkg::orientation_t orientation
);
    localparam tetris_pkg::row_t FLOOR_ROW = tetris_pkg::row_t'(`TETRIS_ROWS - 1);
    localparam tetris_pkg::col_t LAST_COL  = tetris_pkg::col_t'(`TETRIS_COLS - 1);
    localparam tetris_pkg::row_t SPAWN_ROW = tetris_pkg::row_t'(`TETRIS_SPAWN_ROW);
    localparam tetris_pkg::col_t SPAWN_COL = tetris_pkg::col_t'(`TETRIS_SPAWN_COL);

    tetris_pkg::row_t         row_next;
    tetris_pkg::col_t         col_next;
    tetris_pkg::orientation_t orient_next;
    tetris_pkg::orientation_t orient_cw;
    tetris_pkg::orientation_t orient_ccw;

    assign orient_cw  = tetris_pkg::orientation_t'(orientation + 2'd1);
    assign orient_ccw = tetris_pkg::orientation_t'(orientation - 2'd1);

    // each action is built from the current state, later ones win
    always_comb begin
        row_next    = origin_row;
        col_next    = origin_col;
        orient_next = orientation;

        if (rotate_mode) begin
            if (right_press) begin
                row_next    = origin_row;
                col_next    = origin_col;
                orient_next = orient_cw;
            end else if (left_press) begin
                row_next    = origin_row;
                col_next    = origin_col;
                orient_next = orient_ccw;
            end
        end else begin
            // blocked moves leave the column where it is
            if (right_press) begin
                row_next    = origin_row;
                col_next    = (origin_col == LAST_COL) ? origin_col : origin_col + 4'd1;
                orient_next = orientation;
            end else if (left_press) begin
                row_next    = origin_row;
                col_next    = (origin_col == '0) ? origin_col : origin_col - 4'd1;
                orient_next = orientation;
            end
        end

        if (soft_press) begin
            row_next    = (origin_row == FLOOR_ROW) ? origin_row : origin_row + 5'd1;
            col_next    = origin_col;
            orient_next = orientation;
        end

        if (hard_press) begin
            row_next    = FLOOR_ROW;
            col_next    = origin_col;
            orient_next = orientation;
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            origin_row  <= SPAWN_ROW;
            origin_col  <= SPAWN_COL;
            orientation <= tetris_pkg::ORIENT_0;
        end else begin
            origin_row  <= row_next;
            origin_col  <= col_next;
            orientation <= orient_next;
        end
    end

endmodule

/* source/sprint_timer.sv */
// sprint clock: prescaler and cascaded ms to hours counters with run and clear controls
`timescale 1ns/10ps
`include "tetris_defines.svh"

module sprint_timer #(
    parameter int TICKS_PER_MS = `TETRIS_TICKS_PER_MS
) (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       timer_run,
    input  logic                       timer_clear,
    output tetris_pkg::decimal_digit_t milliseconds,
    output tetris_pkg::decimal_digit_t centiseconds,
    output tetris_pkg::decimal_digit_t deciseconds,
    output tetris_pkg::sexagesimal_t   seconds,
    output tetris_pkg::sexagesimal_t   minutes,
    output tetris_pkg::hours_t         hours
);
    localparam int PRE_W = $clog2(TICKS_PER_MS + 1);

    logic [PRE_W-1:0] prescale;
    logic             ms_en;
    logic             cs_en;
    logic             ds_en;
    logic             sec_en;
    logic             min_en;
    logic             hr_en;

    // carry chain, each stage enabled by the wrap of the one below
    assign ms_en  = timer_run && (prescale == PRE_W'(TICKS_PER_MS - 1));
    assign cs_en  = ms_en  && (milliseconds == 4'd9);
    assign ds_en  = cs_en  && (centiseconds == 4'd9);
    assign sec_en = ds_en  && (deciseconds == 4'd9);
    assign min_en = sec_en && (seconds == 6'd59);
    assign hr_en  = min_en && (minutes == 6'd59);

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            prescale <= '0;
        end else if (timer_clear) begin
            prescale <= '0;
        end else if (ms_en) begin
            prescale <= '0;
        end else if (timer_run) begin
            prescale <= prescale + PRE_W'(1);
        end
    end

    always_ff @(posedge clk, negedge rst_l) begin
        if (!rst_l) begin
            milliseconds <= '0;
            centiseconds <= '0;
            deciseconds  <= '0;
            seconds      <= '0;
            minutes      <= '0;
            hours        <= '0;
        end else if (timer_clear) begin
            milliseconds <= '0;
            centiseconds <= '0;
            deciseconds  <= '0;
            seconds      <= '0;
            minutes      <= '0;
            hours        <= '0;
        end else begin
            if (ms_en) begin
                milliseconds <= cs_en ? 4'd0 : milliseconds + 4'd1;
            end
            if (cs_en) begin
                centiseconds <= ds_en ? 4'd0 : centiseconds + 4'd1;
            end
            if (ds_en) begin
                deciseconds <= sec_en ? 4'd0 : deciseconds + 4'd1;
            end
            if (sec_en) begin
                seconds <= min_en ? 6'd0 : seconds + 6'd1;
            end
            if (min_en) begin
                minutes <= hr_en ? 6'd0 : minutes + 6'd1;
            end
            // hours just roll over
            if (hr_en) begin
                hours <= hours + 5'd1;
            end
        end
    end

endmodule

/* source/tetris_sprint_core.sv */
// top level: four key channels feeding the piece tracker, plus the sprint timer
`timescale 1ns/10ps
`include "tetris_defines.svh"

module tetris_sprint_core #(
    parameter int COOLDOWN_CYCLES = `TETRIS_COOLDOWN_CYCLES,
    parameter int TICKS_PER_MS    = `TETRIS_TICKS_PER_MS
) (
    input  logic                       clk,
    input  logic                       rst_l,
    input  logic                       key_left_n,
    input  logic                       key_right_n,
    input  logic                       key_soft_n,
    input  logic                       key_hard_n,
    input  logic                       rotate_mode,
    input  logic                       timer_run,
    input  logic                       timer_clear,
    output tetris_pkg::row_t           origin_row,
    output tetris_pkg::col_t           origin_col,
    output tetris_pkg::orientation_t   orientation,
    output tetris_pkg::decimal_digit_t milliseconds,
    output tetris_pkg::decimal_digit_t centiseconds,
    output tetris_pkg::decimal_digit_t deciseconds,
    output tetris_pkg::sexagesimal_t   seconds,
    output tetris_pkg::sexagesimal_t   minutes,
    output tetris_pkg::hours_t         hours
);
    logic left_press;
    logic right_press;
    logic soft_press;
    logic hard_press;

    // one channel per button
    key_channel #(.COOLDOWN_CYCLES(COOLDOWN_CYCLES)) u_key_left (
        .clk   (clk),
        .rst_l (rst_l),
        .key_n (key_left_n),
        .press (left_press)
    );

    key_channel #(.COOLDOWN_CYCLES(COOLDOWN_CYCLES)) u_key_right (
        .clk   (clk),
        .rst_l (rst_l),
        .key_n (key_right_n),
        .press (right_press)
    );

    key_channel #(.COOLDOWN_CYCLES(COOLDOWN_CYCLES)) u_key_soft (
        .clk   (clk),
        .rst_l (rst_l),
        .key_n (key_soft_n),
        .press (soft_press)
    );

    key_channel #(.COOLDOWN_CYCLES(COOLDOWN_CYCLES)) u_key_hard (
        .clk   (clk),
        .rst_l (rst_l),
        .key_n (key_hard_n),
        .press (hard_press)
    );

    piece_origin_tracker u_tracker (
        .clk         (clk),
        .rst_l       (rst_l),
        .rotate_mode (rotate_mode),
        .left_press  (left_press),
        .right_press (right_press),
        .soft_press  (soft_press),
        .hard_press  (hard_press),
        .origin_row  (origin_row),
        .origin_col  (origin_col),
        .orientation (orientation)
    );

    sprint_timer #(.TICKS_PER_MS(TICKS_PER_MS)) u_timer (
        .clk          (clk),
        .rst_l        (rst_l),
        .timer_run    (timer_run),
        .timer_clear  (timer_clear),
        .milliseconds (milliseconds),
        .centiseconds (centiseconds),
        .deciseconds  (deciseconds),
        .seconds      (seconds),
        .minutes      (minutes),
        .hours        (hours)
    );

endmodule

/* testbench/tetris_assert.sv */
// range assertions on the sprint core outputs, bound into every tetris_sprint_core instance
`timescale 1ns/10ps
`include "tetris_defines.svh"

module tetris_assert (
    input logic                       clk,
    input logic                       rst_l,
    input tetris_pkg::row_t           origin_row,
    input tetris_pkg::col_t           origin_col,
    input tetris_pkg::decimal_digit_t milliseconds,
    input tetris_pkg::decimal_digit_t centiseconds,
    input tetris_pkg::decimal_digit_t deciseconds,
    input tetris_pkg::sexagesimal_t   seconds,
    input tetris_pkg::sexagesimal_t   minutes
);
    localparam tetris_pkg::row_t FLOOR_ROW = tetris_pkg::row_t'(`TETRIS_ROWS - 1);
    localparam tetris_pkg::col_t LAST_COL  = tetris_pkg::col_t'(`TETRIS_COLS - 1);

    // origin stays inside the walls and above the floor
    col_in_field: assert property (@(posedge clk) disable iff (!rst_l) origin_col <= LAST_COL)
        else $error("origin column beyond the right wall");

    row_in_field: assert property (@(posedge clk) disable iff (!rst_l) origin_row <= FLOOR_ROW)
        else $error("origin row below the floor");

    ms_digit: assert property (@(posedge clk) disable iff (!rst_l) milliseconds <= 4'd9)
        else $error("millisecond digit above 9");

    cs_digit: assert property (@(posedge clk) disable iff (!rst_l) centiseconds <= 4'd9)
        else $error("centisecond digit above 9");

    ds_digit: assert property (@(posedge clk) disable iff (!rst_l) deciseconds <= 4'd9)
        else $error("decisecond digit above 9");

    sec_range: assert property (@(posedge clk) disable iff (!rst_l) seconds <= 6'd59)
        else $error("seconds above 59");

    min_range: assert property (@(posedge clk) disable iff (!rst_l) minutes <= 6'd59)
        else $error("minutes above 59");

endmodule

bind tetris_sprint_core tetris_assert u_assert (
    .clk          (clk),
    .rst_l        (rst_l),
    .origin_row   (origin_row),
    .origin_col   (origin_col),
    .milliseconds (milliseconds),
    .centiseconds (centiseconds),
    .deciseconds  (deciseconds),
    .seconds      (seconds),
    .minutes      (minutes)
);

/* testbench/tb_tetris_sprint_core.sv */
// directed testbench and simulation top that drives the sprint core through keys and the timer
`timescale 1ns/10ps
`include "tetris_defines.svh"

module tb_tetris_sprint_core;
    localparam int COOLDOWN   = 8;
    localparam int TICKS      = 4;
    localparam int SETTLE     = 12;
    localparam int GAP        = 14;
    localparam int HOLD_LONG  = 60;
    localparam int RUN_CYCLES = 4938;
    localparam int FLOOR_ROW  = `TETRIS_ROWS - 1;
    localparam int LAST_COL   = `TETRIS_COLS - 1;
    localparam int KEY_LEFT   = 0;
    localparam int KEY_RIGHT  = 1;
    localparam int KEY_SOFT   = 2;
    localparam int KEY_HARD   = 3;

    logic                       clk;
    logic                       rst_l;
    logic                       key_left_n;
    logic                       key_right_n;
    logic                       key_soft_n;
    logic                       key_hard_n;
    logic                       rotate_mode;
    logic                       timer_run;
    logic                       timer_clear;
    tetris_pkg::row_t           origin_row;
    tetris_pkg::col_t           origin_col;
    tetris_pkg::orientation_t   orientation;
    tetris_pkg::decimal_digit_t milliseconds;
    tetris_pkg::decimal_digit_t centiseconds;
    tetris_pkg::decimal_digit_t deciseconds;
    tetris_pkg::sexagesimal_t   seconds;
    tetris_pkg::sexagesimal_t   minutes;
    tetris_pkg::hours_t         hours;

    int                         errors;
    int                         start_errors;
    int                         tests_run;
    int                         tests_failed;
    logic [31:0]                rng_state;
    int                         exp_row;
    int                         exp_col;
    tetris_pkg::orientation_t   exp_orient;

    tetris_sprint_core #(.COOLDOWN_CYCLES(COOLDOWN), .TICKS_PER_MS(TICKS)) u_dut (
        .clk          (clk),
        .rst_l        (rst_l),
        .key_left_n   (key_left_n),
        .key_right_n  (key_right_n),
        .key_soft_n   (key_soft_n),
        .key_hard_n   (key_hard_n),
        .rotate_mode  (rotate_mode),
        .timer_run    (timer_run),
        .timer_clear  (timer_clear),
        .origin_row   (origin_row),
        .origin_col   (origin_col),
        .orientation  (orientation),
        .milliseconds (milliseconds),
        .centiseconds (centiseconds),
        .deciseconds  (deciseconds),
        .seconds      (seconds),
        .minutes      (minutes),
        .hours        (hours)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5;
            clk = !clk;
        end
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic tetris_pkg::orientation_t turn_cw(input tetris_pkg::orientation_t o);
        case (o)
            tetris_pkg::ORIENT_0: return tetris_pkg::ORIENT_R;
            tetris_pkg::ORIENT_R: return tetris_pkg::ORIENT_2;
            tetris_pkg::ORIENT_2: return tetris_pkg::ORIENT_L;
            default:              return tetris_pkg::ORIENT_0;
        endcase
    endfunction

    function automatic tetris_pkg::orientation_t turn_ccw(input tetris_pkg::orientation_t o);
        case (o)
            tetris_pkg::ORIENT_0: return tetris_pkg::ORIENT_L;
            tetris_pkg::ORIENT_L: return tetris_pkg::ORIENT_2;
            tetris_pkg::ORIENT_2: return tetris_pkg::ORIENT_R;
            default:              return tetris_pkg::ORIENT_0;
        endcase
    endfunction

    // elapsed time in ms from the digit weights
    function automatic int timer_total();
        return int'(milliseconds) + 10 * int'(centiseconds) + 100 * int'(deciseconds)
            + 1000 * int'(seconds) + 60000 * int'(minutes) + 3600000 * int'(hours);
    endfunction

    task automatic report_mismatch(input string what, input int expected, input int actual);
        $display("mismatch at %0t: %s expected %0d, got %0d", $time, what, expected, actual);
        errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic start_test();
        start_errors = errors;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors != start_errors) begin
            tests_failed++;
            $display("%s: %0d check(s) failed", name, errors - start_errors);
        end else begin
            $display("%s: ok", name);
        end
    endtask

    task automatic set_key(input int key, input logic level);
        case (key)
            KEY_LEFT:  key_left_n  <= level;
            KEY_RIGHT: key_right_n <= level;
            KEY_SOFT:  key_soft_n  <= level;
            default:   key_hard_n  <= level;
        endcase
    endtask

    task automatic press_key(input int key, input int hold);
        @(posedge clk);
        set_key(key, 1'b0);
        repeat (hold) @(posedge clk);
        set_key(key, 1'b1);
    endtask

    // expected origin after one accepted strobe on an empty field
    task automatic apply_model(input int key);
        if (key == KEY_SOFT) begin
            if (exp_row < FLOOR_ROW) begin
                exp_row = exp_row + 1;
            end
        end else if (key == KEY_HARD) begin
            exp_row = FLOOR_ROW;
        end else if (rotate_mode) begin
            exp_orient = (key == KEY_RIGHT) ? turn_cw(exp_orient) : turn_ccw(exp_orient);
        end else if (key == KEY_RIGHT) begin
            if (exp_col < LAST_COL) begin
                exp_col = exp_col + 1;
            end
        end else if (exp_col > 0) begin
            exp_col = exp_col - 1;
        end
    endtask

    task automatic check_origin();
        if (int'(origin_row) != exp_row) begin
            report_mismatch("origin row", exp_row, int'(origin_row));
        end
        if (int'(origin_col) != exp_col) begin
            report_mismatch("origin column", exp_col, int'(origin_col));
        end
        if (orientation != exp_orient) begin
            report_mismatch("orientation", int'(exp_orient), int'(orientation));
        end
    endtask

    // short random hold gives a single strobe before the wait for the origin
    task automatic press_and_check(input int key);
        tetris_pkg::row_t         row0;
        tetris_pkg::col_t         col0;
        tetris_pkg::orientation_t orient0;
        logic                     moved;
        logic                     changed;
        int                       waited;

        row0    = origin_row;
        col0    = origin_col;
        orient0 = orientation;
        apply_model(key);
        moved = (exp_row != int'(row0)) || (exp_col != int'(col0)) || (exp_orient != orient0);
        press_key(key, int'(next_random() % 32'd6) + 1);
        changed = 1'b0;
        waited  = 0;
        // a blocked press runs the whole window without a change
        while (!changed && waited < SETTLE) begin
            @(negedge clk);
            waited++;
            changed = (origin_row != row0) || (origin_col != col0) || (orientation != orient0);
        end
        if (moved && !changed) begin
            report_timeout("the origin did not change after a key press");
        end
        check_origin();
        repeat (GAP) @(negedge clk);
    endtask

    task automatic test_reset();
        start_test();
        exp_row    = `TETRIS_SPAWN_ROW;
        exp_col    = `TETRIS_SPAWN_COL;
        exp_orient = tetris_pkg::ORIENT_0;
        @(negedge clk);
        check_origin();
        if (timer_total() != 0) begin
            report_mismatch("timer total after reset", 0, timer_total());
        end
        end_test("reset");
    endtask

    task automatic test_moves();
        start_test();
        repeat (6) press_and_check(KEY_LEFT);
        repeat (11) press_and_check(KEY_RIGHT);
        end_test("moves and walls");
    endtask

    task automatic test_rotation();
        start_test();
        @(posedge clk);
        rotate_mode <= 1'b1;
        @(negedge clk);
        repeat (4) press_and_check(KEY_RIGHT);
        repeat (4) press_and_check(KEY_LEFT);
        @(posedge clk);
        rotate_mode <= 1'b0;
        @(negedge clk);
        end_test("rotation");
    endtask

    task automatic test_drops();
        start_test();
        repeat (3) press_and_check(KEY_SOFT);
        press_and_check(KEY_HARD);
        press_and_check(KEY_SOFT);
        end_test("drops");
    endtask

    task automatic test_auto_repeat();
        tetris_pkg::col_t prev_col;
        int               last;
        int               changes;

        start_test();
        if (int'(origin_col) != LAST_COL) begin
            report_mismatch("column before auto-repeat", LAST_COL, int'(origin_col));
        end
        prev_col = origin_col;
        last     = -1;
        changes  = 0;
        @(posedge clk);
        key_left_n <= 1'b0;
        for (int cycle = 0; cycle < HOLD_LONG + SETTLE; cycle++) begin
            @(posedge clk);
            if (cycle == HOLD_LONG) begin
                key_left_n <= 1'b1;
            end
            @(negedge clk);
            if (origin_col != prev_col) begin
                if (last >= 0 && cycle - last < COOLDOWN) begin
                    report_mismatch("minimum cycles between repeats", COOLDOWN, cycle - last);
                end
                changes++;
                last     = cycle;
                prev_col = origin_col;
            end
        end
        if (changes < 2) begin
            $display("error at %0t: a held key moved the column only %0d time(s)", $time, changes);
            errors++;
        end
        exp_col = (LAST_COL - changes < 0) ? 0 : LAST_COL - changes;
        check_origin();
        repeat (GAP) @(negedge clk);
        end_test("auto-repeat and cooldown");
    endtask

    task automatic test_timer();
        int expected_ms;
        int total;
        int waited;

        start_test();
        expected_ms = RUN_CYCLES / TICKS;
        @(posedge clk);
        timer_run <= 1'b1;
        repeat (RUN_CYCLES) @(posedge clk);
        timer_run <= 1'b0;
        @(negedge clk);
        if (int'(milliseconds) > 9) begin
            report_mismatch("millisecond digit limit", 9, int'(milliseconds));
        end
        if (int'(centiseconds) > 9) begin
            report_mismatch("centisecond digit limit", 9, int'(centiseconds));
        end
        if (int'(deciseconds) > 9) begin
            report_mismatch("decisecond digit limit", 9, int'(deciseconds));
        end
        if (int'(seconds) > 59) begin
            report_mismatch("seconds limit", 59, int'(seconds));
        end
        total = timer_total();
        if (total < expected_ms - 1 || total > expected_ms + 1) begin
            report_mismatch("elapsed milliseconds", expected_ms, total);
        end
        // stopped timer must hold
        repeat (20) @(negedge clk);
        if (timer_total() != total) begin
            report_mismatch("frozen timer total", total, timer_total());
        end
        @(posedge clk);
        timer_clear <= 1'b1;
        @(posedge clk);
        timer_clear <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (timer_total() != 0 && waited < SETTLE) begin
            @(negedge clk);
            waited++;
        end
        if (timer_total() != 0) begin
            report_timeout("the timer did not return to zero after a clear");
        end
        end_test("sprint timer");
    endtask

    initial begin
        rst_l        = 1'b0;
        key_left_n   = 1'b1;
        key_right_n  = 1'b1;
        key_soft_n   = 1'b1;
        key_hard_n   = 1'b1;
        rotate_mode  = 1'b0;
        timer_run    = 1'b0;
        timer_clear  = 1'b0;
        rng_state    = 32'd77;
        errors       = 0;
        start_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (4) @(posedge clk);
        rst_l <= 1'b1;

        test_reset();
        test_moves();
        test_rotation();
        test_drops();
        test_auto_repeat();
        test_timer();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/tetris_pkg.sv
source/key_channel.sv
source/piece_origin_tracker.sv
source/sprint_timer.sv
source/tetris_sprint_core.sv
testbench/tetris_assert.sv
testbench/tb_tetris_sprint_core.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, and pass only when the testbench prints its pass line
verilator --binary --timing --timescale 1ns/10ps -f compile.f \
    --top-module tb_tetris_sprint_core -o sim_tetris \
    && ./obj_dir/sim_tetris | tee /dev/stderr | grep "TEST PASSED" > /dev/null \
    && echo "run.sh: simulation ok" && exit 0 \
    || { echo "run.sh: simulation reported failure or did not build"; exit 1; }
